/* files.f */
verilog/mandel_math_pkg.sv
verilog/fb_pkg.sv
verilog/view_ctrl.sv
verilog/mandel_iter.sv
verilog/render_scan.sv
verilog/fb_write.sv
verilog/mandel_top.sv
tb/mandel_checker.sv
tb/mandel_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the renderer testbench with verilator, run it, search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module mandel_tb -f files.f \
    -o mandel_sim > build.log 2>&1 \
    && ./obj_dir/mandel_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat build.log sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* tb/mandel_checker.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// render protocol assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mandel_checker (
    input logic clk_sys,
    input logic rst_sys,
    input logic start,
    input logic busy,
    input logic done
);

    // no kick into a running render
    start_idle: assert property (@(posedge clk_sys) disable iff (rst_sys) start |-> !busy)
        else $error("start pulsed while busy was high");

    // done only closes a render
    done_busy: assert property (@(posedge clk_sys) disable iff (rst_sys) done |-> $past(busy))
        else $error("done high without busy in the cycle before");

    busy_reset: assert property (@(posedge clk_sys) rst_sys |=> !busy)
        else $error("busy high after a reset cycle");

endmodule

bind mandel_top mandel_checker checker_inst (.clk_sys, .rst_sys, .start, .busy, .done);

/* tb/mandel_tb.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mandelbrot renderer testbench
// button table, pixel model and framebuffer readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mandel_tb import mandel_math_pkg::*, fb_pkg::*; ();

    typedef enum logic [2:0] {ACT_NONE, ACT_FIRE, ACT_UP, ACT_DOWN, ACT_DOWN_BUSY_UP} action_t;

    localparam int NUM_ROWS = 10;
    // worst pixel costs ITER_MAX iterations plus launch, load and done cycles
    localparam int CYCLE_LIMIT = NUM_ROWS * FB_PIXELS * (ITER_MAX + 4)
                               + NUM_ROWS * (FB_PIXELS + 40) + 200;

    logic                clk_sys;
    logic                rst_sys;
    logic                btn_fire, btn_up, btn_dn;
    logic [FB_ADDRW-1:0] rd_addr;
    logic [CIDXW-1:0]    rd_data;
    fp_t                 x_start, y_start, step;
    logic                busy, done;

    string   row_name   [NUM_ROWS];
    action_t row_act    [NUM_ROWS];
    logic    row_render [NUM_ROWS];  // render expected
    fp_t     row_x [NUM_ROWS];       // expected view after the row
    fp_t     row_y [NUM_ROWS];
    fp_t     row_s [NUM_ROWS];
    int      errors = 0;
    int      cycles = 0;
    int      r;

    mandel_top uut (.clk_sys, .rst_sys, .btn_fire, .btn_up, .btn_dn, .rd_addr,
                    .rd_data, .x_start, .y_start, .step, .busy, .done);

    always #5 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic set_row(input int i, input string name, input action_t act,
                           input logic render, input fp_t x, input fp_t y, input fp_t s);
        row_name[i]   = name;
        row_act[i]    = act;
        row_render[i] = render;
        row_x[i]      = x;
        row_y[i]      = y;
        row_s[i]      = s;
    endtask

    task automatic check_val(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // escape count of one pixel, products wrapped back to Q4.21
    function automatic int ref_pixel(input fp_t x0, input fp_t y0, input fp_t s,
                                     input int px, input int py);
        fp_t    cx, cy, zx, zy, xx, yy, xy;
        longint mag;
        int     count;
        bit     stop;
        cx    = fp_t'(longint'(x0) + longint'(px) * longint'(s));
        cy    = fp_t'(longint'(y0) + longint'(py) * longint'(s));
        zx    = '0;
        zy    = '0;
        count = 0;
        stop  = 1'b0;
        while (!stop) begin
            xx  = fp_t'((longint'(zx) * longint'(zx)) >>> FP_FRAC);
            yy  = fp_t'((longint'(zy) * longint'(zy)) >>> FP_FRAC);
            xy  = fp_t'((longint'(zx) * longint'(zy)) >>> FP_FRAC);
            mag = longint'(xx) + longint'(yy);
            if (mag > (longint'(4) <<< FP_FRAC) || count == ITER_MAX) begin
                stop = 1'b1;  // escaped or out of iterations
            end else begin
                zx    = fp_t'(longint'(xx) - longint'(yy) + longint'(cx));
                zy    = fp_t'(2 * longint'(xy) + longint'(cy));
                count = count + 1;
            end
        end
        return count;
    endfunction

    // one-cycle pulse, driven 1 ns after the edge
    task automatic press_button(input action_t act);
        btn_fire = (act == ACT_FIRE);
        btn_up   = (act == ACT_UP);
        btn_dn   = (act == ACT_DOWN) || (act == ACT_DOWN_BUSY_UP);
        @(posedge clk_sys);
        #1;
        btn_fire = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
    endtask

    task automatic wait_for_done();
        do begin
            @(posedge clk_sys);
            #1;
        end while (!done);
    endtask

    // busy must stay low when no render is due
    task automatic watch_idle(input string name);
        logic seen_busy;
        seen_busy = 1'b0;
        repeat (20) begin
            @(posedge clk_sys);
            #1;
            if (busy) seen_busy = 1'b1;
        end
        check_val({name, " busy"}, 0, seen_busy);
    endtask

    // whole image in a shuffled order
    task automatic read_image(input int i);
        int order [FB_PIXELS];
        int k, j, tmp;
        for (k = 0; k < FB_PIXELS; k++) order[k] = k;
        for (k = FB_PIXELS - 1; k > 0; k--) begin
            j        = int'($urandom % (k + 1));
            tmp      = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (k = 0; k < FB_PIXELS; k++) begin
            rd_addr = FB_ADDRW'(order[k]);
            @(posedge clk_sys);
            #1;  // registered read, one cycle
            check_val($sformatf("%s pixel %0d", row_name[i], order[k]),
                      ref_pixel(row_x[i], row_y[i], row_s[i],
                                order[k] % FB_WIDTH, order[k] / FB_WIDTH),
                      rd_data);
        end
    endtask

    initial begin
        clk_sys  = 1'b0;
        rst_sys  = 1'b1;
        btn_fire = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        rd_addr  = '0;
        void'($urandom(32'hed2743ca));
        set_row(0, "reset_view", ACT_NONE, 1'b1, X_START, Y_START, STEP_INIT);
        set_row(1, "pan_right", ACT_DOWN, 1'b1, X_START + (STEP_INIT <<< 1), Y_START, STEP_INIT);
        set_row(2, "pan_left", ACT_UP, 1'b1, X_START, Y_START, STEP_INIT);
        set_row(3, "fire_vertical", ACT_FIRE, 1'b0, X_START, Y_START, STEP_INIT);
        set_row(4, "pan_up", ACT_UP, 1'b1, X_START, Y_START - (STEP_INIT <<< 1), STEP_INIT);
        set_row(5, "fire_zoom", ACT_FIRE, 1'b0, X_START, Y_START - (STEP_INIT <<< 1), STEP_INIT);
        // zoom in from y_start - 2 steps brings the top edge back
        set_row(6, "zoom_in", ACT_DOWN, 1'b1, X_START + (STEP_INIT <<< 2), Y_START,
                STEP_INIT >>> 1);
        set_row(7, "zoom_out", ACT_UP, 1'b1, X_START, Y_START - (STEP_INIT <<< 1), STEP_INIT);
        set_row(8, "zoom_out_limit", ACT_UP, 1'b0, X_START, Y_START - (STEP_INIT <<< 1),
                STEP_INIT);
        set_row(9, "busy_ignored", ACT_DOWN_BUSY_UP, 1'b1, X_START + (STEP_INIT <<< 2),
                Y_START, STEP_INIT >>> 1);
        repeat (4) @(posedge clk_sys);
        #1;
        rst_sys = 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            if (row_act[r] != ACT_NONE) press_button(row_act[r]);
            if (row_act[r] == ACT_DOWN_BUSY_UP) begin
                while (!busy) begin
                    @(posedge clk_sys);
                    #1;
                end
                press_button(ACT_UP);  // lands mid render
            end
            if (row_render[r]) begin
                wait_for_done();
                repeat (2) @(posedge clk_sys);  // last write lands after done
                #1;
            end else begin
                watch_idle(row_name[r]);
            end
            check_val({row_name[r], " x_start"}, row_x[r], x_start);
            check_val({row_name[r], " y_start"}, row_y[r], y_start);
            check_val({row_name[r], " step"}, row_s[r], step);
            read_image(r);
            check_val({row_name[r], " idle after readback"}, 0, busy);
        end
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/fb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer package
// grid geometry and pixel word widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fb_pkg;

    // grid size in pixels
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 9;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 144 words

    localparam int FB_ADDRW = $clog2(FB_PIXELS);  // 8 bits
    localparam int CIDXW    = 8;                  // colour index bits

    // pixel coordinate, room for the 16 wide row
    typedef logic [4:0] coord_t;

endpackage

/* verilog/fb_write.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer, result stage
// address pipeline and memory with a read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fb_write import fb_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                draw,       // write strobe
    input  coord_t              draw_x,
    input  coord_t              draw_y,
    input  logic [CIDXW-1:0]    draw_cidx,
    input  logic [FB_ADDRW-1:0] rd_addr,
    output logic [CIDXW-1:0]    rd_data     // valid one cycle after rd_addr
);

    logic [CIDXW-1:0] mem [0:FB_PIXELS-1];

    // stage one
    logic [FB_ADDRW-1:0] row_off;  // y times width
    coord_t              col;
    logic                we_1;
    logic [CIDXW-1:0]    cidx_1;

    // stage two
    logic [FB_ADDRW-1:0] wr_addr;
    logic                we_2;
    logic [CIDXW-1:0]    cidx_2;

    always_ff @(posedge clk_sys) begin
        row_off <= FB_ADDRW'(draw_y * FB_WIDTH);
        col     <= draw_x;
        cidx_1  <= draw_cidx;
        wr_addr <= row_off + FB_ADDRW'(col);
        cidx_2  <= cidx_1;
        // write enable delayed to line up with the address
        if (rst_sys) begin
            we_1 <= 1'b0;
            we_2 <= 1'b0;
        end else begin
            we_1 <= draw;
            we_2 <= we_1;
        end
    end

    // one write port, two cycles after draw
    always_ff @(posedge clk_sys) begin
        if (we_2) mem[wr_addr] <= cidx_2;
    end

    always_ff @(posedge clk_sys) begin
        rd_data <= mem[rd_addr];  // registered read
    end

endmodule

/* verilog/mandel_iter.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// escape-time core
// one iteration of z = z^2 + c per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mandel_iter import mandel_math_pkg::*, fb_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  logic             iter_go,    // load new point, taken when idle
    input  fp_t              cx,         // real part of c
    input  fp_t              cy,         // imaginary part of c
    output logic             iter_done,  // one-cycle end pulse
    output logic [CIDXW-1:0] iter_count  // final count, stable after done
);

    logic running;
    fp_t  cx_r, cy_r;  // c held for the whole run
    fp_t  zx, zy;      // current z

    // full products before truncation
    logic signed [2*FP_WIDTH-1:0] xx_full;
    logic signed [2*FP_WIDTH-1:0] yy_full;
    logic signed [2*FP_WIDTH-1:0] xy_full;
    fp_t  xx, yy, xy;               // back in Q4.21
    logic signed [FP_WIDTH:0] mag;  // one bit of headroom for the sum
    logic finish;                   // escaped or out of iterations

    always_comb begin
        xx_full = zx * zx;
        yy_full = zy * zy;
        xy_full = zx * zy;
        // shift by the fraction then drop the top bits
        xx = fp_t'(xx_full >>> FP_FRAC);
        yy = fp_t'(yy_full >>> FP_FRAC);
        xy = fp_t'(xy_full >>> FP_FRAC);
        mag = xx + yy;
        finish = (mag > (4 <<< FP_FRAC)) || (iter_count == CIDXW'(ITER_MAX));
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            running   <= 1'b0;
            iter_done <= 1'b0;
        end else begin
            iter_done <= 1'b0;
            if (!running) begin
                if (iter_go) begin  // load cycle
                    running    <= 1'b1;
                    zx         <= '0;
                    zy         <= '0;
                    cx_r       <= cx;
                    cy_r       <= cy;
                    iter_count <= '0;
                end
            end else if (finish) begin
                running   <= 1'b0;
                iter_done <= 1'b1;
            end else begin
                zx         <= xx - yy + cx_r;       // re(z^2) + cx
                zy         <= (xy <<< 1) + cy_r;    // 2xy + cy
                iter_count <= iter_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/mandel_math_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mandelbrot maths package
// fixed-point format, iteration limit and start view
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mandel_math_pkg;

    // Q4.21 signed fixed point
    localparam int FP_WIDTH = 25;                  // total width
    localparam int FP_INT   = 4;                   // integer bits incl sign
    localparam int FP_FRAC  = FP_WIDTH - FP_INT;   // 21 fraction bits

    localparam int ITER_MAX = 31;  // highest count, fits the colour index

    typedef logic signed [FP_WIDTH-1:0] fp_t;

    // window at reset
    // 16 x 9 grid at 1/4 covers -2.5..1.25 by -1.125..0.875
    localparam fp_t X_START   = fp_t'(-(5 <<< (FP_FRAC - 1)));  // -2.5
    localparam fp_t Y_START   = fp_t'(-(9 <<< (FP_FRAC - 3)));  // -1.125
    localparam fp_t STEP_INIT = fp_t'(1 <<< (FP_FRAC - 2));     // 1/4, also zoom-out limit

    // controller modes, fire cycles through them in order
    typedef enum logic [1:0] {
        HORIZONTAL,  // up/dn pan x
        VERTICAL,    // up/dn pan y
        ZOOM         // up out, dn in
    } view_mode_t;

endpackage

/* verilog/mandel_top.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mandelbrot renderer top
// decode, execute and result stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mandel_top import mandel_math_pkg::*, fb_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                btn_fire,
    input  logic                btn_up,
    input  logic                btn_dn,
    input  logic [FB_ADDRW-1:0] rd_addr,
    output logic [CIDXW-1:0]    rd_data,
    output fp_t                 x_start,  // committed view
    output fp_t                 y_start,
    output fp_t                 step,
    output logic                busy,
    output logic                done
);

    logic             start;
    logic             iter_go, iter_done;
    logic [CIDXW-1:0] iter_count;
    fp_t              cx, cy;       // point under iteration
    logic             draw;
    coord_t           draw_x, draw_y;
    logic [CIDXW-1:0] draw_cidx;

    // decode
    view_ctrl view_ctrl_inst (
        .clk_sys, .rst_sys, .btn_fire, .btn_up, .btn_dn, .busy,
        .start, .x_start, .y_start, .step
    );

    // execute
    render_scan render_scan_inst (
        .clk_sys, .rst_sys, .start, .x_start, .y_start, .step,
        .iter_done, .iter_count, .iter_go, .cx, .cy,
        .busy, .done, .draw, .draw_x, .draw_y, .draw_cidx
    );

    mandel_iter mandel_iter_inst (
        .clk_sys, .rst_sys, .iter_go, .cx, .cy, .iter_done, .iter_count
    );

    // result
    fb_write fb_write_inst (
        .clk_sys, .rst_sys, .draw, .draw_x, .draw_y, .draw_cidx,
        .rd_addr, .rd_data
    );

endmodule

/* verilog/render_scan.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// render scan, execute stage
// walks the grid and draws one colour index per pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module render_scan import mandel_math_pkg::*, fb_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  logic             start,      // latch view and begin
    input  fp_t              x_start,
    input  fp_t              y_start,
    input  fp_t              step,
    input  logic             iter_done,
    input  logic [CIDXW-1:0] iter_count,
    output logic             iter_go,    // launch pulse to the core
    output fp_t              cx,
    output fp_t              cy,
    output logic             busy,
    output logic             done,       // one cycle after last draw
    output logic             draw,       // write strobe
    output coord_t           draw_x,
    output coord_t           draw_y,
    output logic [CIDXW-1:0] draw_cidx
);

    fp_t    x_left;   // row start, reloaded into cx
    fp_t    step_r;   // step latched on start
    coord_t px, py;   // pixel in the core
    logic   last_px;
    logic   finish;   // last draw out, done next

    assign last_px = (px == coord_t'(FB_WIDTH - 1)) && (py == coord_t'(FB_HEIGHT - 1));

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            draw    <= 1'b0;
            iter_go <= 1'b0;
            finish  <= 1'b0;
            px      <= '0;
            py      <= '0;
        end else begin
            iter_go <= 1'b0;
            draw    <= 1'b0;
            done    <= 1'b0;
            if (done) busy <= 1'b0;  // busy drops after the done cycle
            if (start && !busy) begin
                busy    <= 1'b1;
                iter_go <= 1'b1;  // first pixel straight away
                x_left  <= x_start;
                step_r  <= step;
                cx      <= x_start;
                cy      <= y_start;
                px      <= '0;
                py      <= '0;
            end else if (busy && iter_done) begin
                draw      <= 1'b1;
                draw_x    <= px;
                draw_y    <= py;
                draw_cidx <= iter_count;  // colour is the count
                if (last_px) begin
                    finish <= 1'b1;
                end else begin
                    iter_go <= 1'b1;
                    // running sums, no multiply per pixel
                    if (px == coord_t'(FB_WIDTH - 1)) begin
                        px <= '0;
                        py <= py + 1'b1;
                        cx <= x_left;
                        cy <= cy + step_r;
                    end else begin
                        px <= px + 1'b1;
                        cx <= cx + step_r;
                    end
                end
            end
            if (finish) begin
                finish <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

endmodule

/* verilog/view_ctrl.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// view controller, decode stage
// turns button pulses into pan and zoom of the window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module view_ctrl import mandel_math_pkg::*; (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic btn_fire,  // next mode
    input  logic btn_up,
    input  logic btn_dn,
    input  logic busy,      // render running
    output logic start,     // one-cycle render kick
    output fp_t  x_start,   // left edge
    output fp_t  y_start,   // top edge
    output fp_t  step       // distance between pixels
);

    view_mode_t mode;
    logic changed;          // initial render waiting for commit
    logic render_required;  // view committed, start due next
    logic move;             // up or down decoded this cycle
    logic idle;
    logic step_ok;
    fp_t  x_nxt, y_nxt, step_nxt;  // pending view

    // no new view while a render runs or one is on its way
    assign idle = !busy && !render_required && !start;

    // limit check on the pending step
    assign step_ok = (step_nxt != '0) && (step_nxt <= STEP_INIT);

    always_comb begin
        x_nxt    = x_start;  // hold by default
        y_nxt    = y_start;
        step_nxt = step;
        move     = 1'b0;
        if ((btn_up || btn_dn) && !changed) begin
            move = 1'b1;
            case (mode)
                HORIZONTAL: begin  // pan by two steps
                    if (btn_up) x_nxt = x_start - (step <<< 1);
                    else        x_nxt = x_start + (step <<< 1);
                end
                VERTICAL: begin
                    if (btn_up) y_nxt = y_start - (step <<< 1);
                    else        y_nxt = y_start + (step <<< 1);
                end
                default: begin
                    // zoom about the grid centre, 8 steps in x and about 4 in y
                    if (btn_up) begin
                        x_nxt    = x_start - (step <<< 3);
                        y_nxt    = y_start - (step <<< 2);
                        step_nxt = step <<< 1;
                    end else begin
                        x_nxt    = x_start + (step <<< 2);
                        y_nxt    = y_start + (step <<< 1);
                        step_nxt = step >>> 1;  // arithmetic halving
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            mode            <= HORIZONTAL;
            x_start         <= X_START;
            y_start         <= Y_START;
            step            <= STEP_INIT;
            changed         <= 1'b1;  // first frame drawn without a button
            render_required <= 1'b0;
            start           <= 1'b0;
        end else begin
            start <= 1'b0;
            if (btn_fire) begin  // fire is never blocked
                case (mode)
                    HORIZONTAL: mode <= VERTICAL;
                    VERTICAL:   mode <= ZOOM;
                    default:    mode <= HORIZONTAL;
                endcase
            end
            if (idle && (changed || move)) begin
                changed <= 1'b0;
                if (step_ok) begin  // bad zoom leaves view alone
                    x_start         <= x_nxt;
                    y_start         <= y_nxt;
                    step            <= step_nxt;
                    render_required <= 1'b1;
                end
            end else if (render_required) begin
                render_required <= 1'b0;
                start           <= 1'b1;
            end
        end
    end

endmodule
